// File: qcore_lite.f
+incdir+verilog
verilog/qcore_pkg.sv
verilog/qcore_alu.sv
verilog/qcore_fetch.sv
verilog/qcore_decode.sv
verilog/qcore_reg_bank.sv
verilog/qcore_execute.sv
verilog/qcore_result.sv
verilog/qcore_top.sv
tb/tb_qcore.sv

// File: run.sh
#!/bin/sh
# Build and run the qcore_lite simulation with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal \
   -f qcore_lite.f \
   --top-module tb_qcore \
   -o sim_qcore
./obj_dir/sim_qcore

// File: tb/tb_qcore.sv
// Testbench for qcore_top with memory models, program builders, directed tests and check task

`include "qcore_macros.svh"

module tb_qcore;

   logic                      clk_i = 1'b0, rst_ni = 1'b0, en_i = 1'b1, flag_i = 1'b0;
   logic [`QCORE_INSTR_W-1:0] pmem_dt_i = '0;
   logic [`QCORE_DATA_W-1:0]  dmem_r_dt_i = '0;
   logic [`QCORE_PMEM_AW-1:0] pmem_addr_o;
   logic                      pmem_en_o, dmem_we_o;
   logic [`QCORE_DMEM_AW-1:0] dmem_addr_o;
   logic [`QCORE_DATA_W-1:0]  dmem_w_dt_o;

   logic [`QCORE_INSTR_W-1:0] prog [256];
   logic [`QCORE_DATA_W-1:0]  dmem [256];
   logic [31:0]               exp_addr[$], exp_data[$], got_addr[$], got_data[$];
   integer                    seed = 32'h6d1;
   int                        wp;  // Next program slot

   qcore_top qcore_top_i (.*);

   always #2 clk_i = ~clk_i;

   ////////////////////////////////////////////////////////////////////
   // Memory models with one cycle read latency
   always @(posedge clk_i) begin
      if (!en_i && (pmem_en_o || dmem_we_o)) begin
         $display("Memory enable seen while the core is halted");
         $display("Result: FAILED");
         $fatal(1);
      end
      if (pmem_en_o) pmem_dt_i <= prog[pmem_addr_o];
      if (dmem_we_o) begin
         dmem[dmem_addr_o] <= dmem_w_dt_o;
         got_addr.push_back(32'(dmem_addr_o));
         got_data.push_back(dmem_w_dt_o);
      end
      dmem_r_dt_i <= dmem[dmem_addr_o];
   end

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("Fail %s: expected %h, got %h", name, exp, act);
         $display("Result: FAILED");
         $fatal(1);
      end
   endtask

   ////////////////////////////////////////////////////////////////////
   // Instruction builders
   function automatic qcore_pkg::instr_t mk(input qcore_pkg::header_e hdr,
         input qcore_pkg::cond_e cond, input qcore_pkg::alu_op_e op, input logic fwe,
         input qcore_pkg::reg_src_e src, input logic [3:0] rd, input logic [3:0] rs0,
         input logic [3:0] rs1, input logic [31:0] imm);
      qcore_pkg::instr_t i;
      i         = '0;
      i.header  = hdr;
      i.cond    = cond;
      i.alu_op  = op;
      i.flag_we = fwe;
      i.src     = src;
      i.rd      = rd;
      i.rs0     = rs0;
      i.rs1     = rs1;
      i.imm     = imm;
      return i;
   endfunction

   task automatic emit(input qcore_pkg::instr_t i);
      prog[wp] = i;
      wp++;
   endtask

   task automatic load_imm(input logic [3:0] rd, input logic [31:0] v);
      emit(mk(qcore_pkg::REG_WR, qcore_pkg::ALWAYS, qcore_pkg::ADD, 1'b0,
              qcore_pkg::IMM, rd, 4'd0, 4'd0, v));
   endtask

   task automatic alu_op(input qcore_pkg::alu_op_e op, input qcore_pkg::reg_src_e src,
         input logic fwe, input logic [3:0] rd, input logic [3:0] a, input logic [3:0] b,
         input logic [31:0] imm);
      emit(mk(qcore_pkg::REG_WR, qcore_pkg::ALWAYS, op, fwe, src, rd, a, b, imm));
   endtask

   // Store rs1 to rs0 + offset
   task automatic store(input logic [3:0] base, input logic [3:0] dreg, input logic [7:0] off);
      emit(mk(qcore_pkg::MEM_WR, qcore_pkg::ALWAYS, qcore_pkg::ADD, 1'b0,
              qcore_pkg::ALU_RR, 4'd0, base, dreg, 32'(off)));
   endtask

   task automatic branch(input qcore_pkg::cond_e c, input int target);
      emit(mk(qcore_pkg::BRANCH, c, qcore_pkg::ADD, 1'b0, qcore_pkg::IMM,
              4'd0, 4'd0, 4'd0, 32'(target)));
   endtask

   task automatic new_program();
      for (int a = 0; a < 256; a++)
         prog[a] = {32'h0, 32'(a) ^ 32'h00a5_0000};  // NOP words with the address in imm
      wp = 0;
      exp_addr.delete();
      exp_data.delete();
   endtask

   task automatic expect_store(input logic [7:0] addr, input logic [31:0] dt);
      exp_addr.push_back(32'(addr));
      exp_data.push_back(dt);
   endtask

   ////////////////////////////////////////////////////////////////////
   // Reset and run until all expected stores are seen, with an optional halt window
   task automatic run_program(input int halt_at, input int halt_len);
      int cyc;
      @(negedge clk_i);
      rst_ni = 1'b0;
      en_i   = 1'b1;
      repeat (10) @(negedge clk_i);
      got_addr.delete();
      got_data.delete();
      rst_ni = 1'b1;
      cyc    = 0;
      while (got_addr.size() < exp_addr.size()) begin
         if (cyc == halt_at) en_i = 1'b0;
         if (cyc == halt_at + halt_len) en_i = 1'b1;
         if (cyc >= 2000) begin
            $display("Timeout waiting for data memory stores");
            $display("Result: FAILED");
            $fatal(1);
         end
         @(negedge clk_i);
         cyc++;
      end
      en_i = 1'b1;
      for (int d = 0; d < 24; d++) @(negedge clk_i);  // Catch any stray store
      check("store_count", 32'(exp_addr.size()), 32'(got_addr.size()));
      foreach (exp_addr[k]) begin
         check("dmem_addr_o", exp_addr[k], got_addr[k]);
         check("dmem_w_dt_o", exp_data[k], got_data[k]);
      end
   endtask

   function automatic logic [31:0] alu_model(input int op, input logic [31:0] a, b);
      case (op)
         0: return a + b;
         1: return a - b;
         2: return a & b;
         3: return a | b;
         4: return a ^ b;
         5: return a << b[4:0];
         6: return a >> b[4:0];
         7: return b;
         default: return 32'h0;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////
   // Directed tests
   task automatic alu_ops_test();
      logic [31:0] a, b, c;
      a = $random(seed);
      b = $random(seed);
      c = $random(seed);
      new_program();
      load_imm(4'd1, a);
      load_imm(4'd2, b);
      for (int k = 0; k < 8; k++) begin
         alu_op(qcore_pkg::alu_op_e'(k), qcore_pkg::ALU_RR, 1'b0, 4'd3, 4'd1, 4'd2, 32'h0);
         store(4'd0, 4'd3, 8'(k));
         expect_store(8'(k), alu_model(k, a, b));
         alu_op(qcore_pkg::alu_op_e'(k), qcore_pkg::ALU_RI, 1'b0, 4'd4, 4'd1, 4'd0, c);
         store(4'd0, 4'd4, 8'(8 + k));
         expect_store(8'(8 + k), alu_model(k, a, c));
      end
      branch(qcore_pkg::ALWAYS, wp);
      run_program(-1, 0);
   endtask

   task automatic hazard_chain_test();
      logic [31:0] x;
      x = $random(seed);
      new_program();
      load_imm(4'd1, x);
      alu_op(qcore_pkg::ADD, qcore_pkg::ALU_RI, 1'b0, 4'd2, 4'd1, 4'd0, 32'd7);
      alu_op(qcore_pkg::ADD, qcore_pkg::ALU_RR, 1'b0, 4'd3, 4'd2, 4'd1, 32'h0);
      alu_op(qcore_pkg::ADD, qcore_pkg::ALU_RR, 1'b0, 4'd4, 4'd3, 4'd2, 32'h0);
      alu_op(qcore_pkg::ADD, qcore_pkg::ALU_RR, 1'b0, 4'd1, 4'd4, 4'd4, 32'h0);
      store(4'd0, 4'd1, 8'h50);
      store(4'd0, 4'd3, 8'h51);
      branch(qcore_pkg::ALWAYS, wp);
      expect_store(8'h50, 32'd6 * x + 32'd28);
      expect_store(8'h51, 32'd2 * x + 32'd7);
      run_program(-1, 0);
   endtask

   task automatic build_load_program();
      logic [31:0] v1, v2;
      v1 = $random(seed);
      v2 = $random(seed);
      new_program();
      load_imm(4'd1, v1);
      load_imm(4'd2, v2);
      store(4'd0, 4'd1, 8'h40);
      store(4'd0, 4'd2, 8'h41);
      load_imm(4'd8, 32'h40);
      emit(mk(qcore_pkg::REG_WR, qcore_pkg::ALWAYS, qcore_pkg::ADD, 1'b0,
              qcore_pkg::LOAD, 4'd9, 4'd0, 4'd0, 32'h60));  // Word never stored
      emit(mk(qcore_pkg::REG_WR, qcore_pkg::ALWAYS, qcore_pkg::ADD, 1'b0,
              qcore_pkg::LOAD, 4'd5, 4'd0, 4'd0, 32'h40));
      emit(mk(qcore_pkg::REG_WR, qcore_pkg::ALWAYS, qcore_pkg::ADD, 1'b0,
              qcore_pkg::LOAD, 4'd6, 4'd8, 4'd0, 32'h1));   // Base plus offset
      alu_op(qcore_pkg::ADD, qcore_pkg::ALU_RR, 1'b0, 4'd7, 4'd5, 4'd6, 32'h0);
      store(4'd0, 4'd7, 8'h42);
      store(4'd0, 4'd9, 8'h43);
      branch(qcore_pkg::ALWAYS, wp);
      expect_store(8'h40, v1);
      expect_store(8'h41, v2);
      expect_store(8'h42, v1 + v2);
      expect_store(8'h43, dmem[8'h60]);  // Initial fill of the data array
   endtask

   task automatic load_store_test(input int halt_at, input int halt_len);
      build_load_program();
      run_program(halt_at, halt_len);
   endtask

   // Flag-setting pass and branch, then two stores that a taken branch must discard
   task automatic branch_case(input qcore_pkg::cond_e c, input logic [31:0] v,
         input logic flag);
      logic taken;
      case (c)
         qcore_pkg::EQ:    taken = (v == 32'h0);
         qcore_pkg::LT:    taken = v[31];
         qcore_pkg::NZ:    taken = (v != 32'h0);
         qcore_pkg::NS:    taken = ~v[31];
         qcore_pkg::FLAG:  taken = flag;
         qcore_pkg::NFLAG: taken = ~flag;
         default:          taken = 1'b0;
      endcase
      new_program();
      load_imm(4'd2, 32'h111);  // Fall-through marker
      load_imm(4'd3, 32'h222);  // Taken marker
      alu_op(qcore_pkg::PASS_B, qcore_pkg::ALU_RI, 1'b1, 4'd1, 4'd0, 4'd0, v);
      branch(c, 7);
      store(4'd0, 4'd2, 8'h20);
      store(4'd0, 4'd2, 8'h21);
      branch(qcore_pkg::ALWAYS, 6);
      store(4'd0, 4'd3, 8'h30);  // Slot 7
      branch(qcore_pkg::ALWAYS, 8);
      if (taken) begin
         expect_store(8'h30, 32'h222);
      end else begin
         expect_store(8'h20, 32'h111);
         expect_store(8'h21, 32'h111);
      end
      @(negedge clk_i);
      flag_i = flag;
      run_program(-1, 0);
   endtask

   task automatic branch_cond_test();
      branch_case(qcore_pkg::EQ, 32'h0, 1'b0);
      branch_case(qcore_pkg::EQ, 32'h5, 1'b0);
      branch_case(qcore_pkg::LT, 32'h8000_0003, 1'b0);
      branch_case(qcore_pkg::LT, 32'h5, 1'b0);
      branch_case(qcore_pkg::NZ, 32'h5, 1'b0);
      branch_case(qcore_pkg::NZ, 32'h0, 1'b0);
      branch_case(qcore_pkg::NS, 32'h5, 1'b0);
      branch_case(qcore_pkg::NS, 32'hffff_fff0, 1'b0);
   endtask

   task automatic flag_halt_test();
      branch_case(qcore_pkg::FLAG, 32'h1, 1'b1);
      branch_case(qcore_pkg::FLAG, 32'h1, 1'b0);
      branch_case(qcore_pkg::NFLAG, 32'h1, 1'b1);
      branch_case(qcore_pkg::NFLAG, 32'h1, 1'b0);
      for (int h = 2; h < 16; h += 2)
         load_store_test(h, 7);  // Halt window slides over stores and loads
   endtask

   initial begin
      for (int a = 0; a < 256; a++)
         dmem[a] = {24'h5a5a00, 8'(a)} ^ (32'(a) << 20);
      alu_ops_test();
      hazard_chain_test();
      load_store_test(-1, 0);
      branch_cond_test();
      flag_halt_test();
      $display("Result: PASSED");
      $finish;
   end

endmodule

// File: verilog/qcore_alu.sv
// Two-input ALU with zero and sign flags

`include "qcore_macros.svh"

module qcore_alu (
   input  logic [`QCORE_DATA_W-1:0] a_i,
   input  logic [`QCORE_DATA_W-1:0] b_i,
   input  qcore_pkg::alu_op_e       op_i,
   output logic [`QCORE_DATA_W-1:0] result_o,
   output logic                     z_o,
   output logic                     s_o
);

   always_comb begin
      case (op_i)
         qcore_pkg::ADD:    result_o = a_i + b_i;
         qcore_pkg::SUB:    result_o = a_i - b_i;
         qcore_pkg::AND:    result_o = a_i & b_i;
         qcore_pkg::OR:     result_o = a_i | b_i;
         qcore_pkg::XOR:    result_o = a_i ^ b_i;
         qcore_pkg::SHL:    result_o = a_i << b_i[4:0];  // Low five bits only
         qcore_pkg::SHR:    result_o = a_i >> b_i[4:0];  // Logical
         qcore_pkg::PASS_B: result_o = b_i;
         default:           result_o = '0;
      endcase
   end

   assign z_o = (result_o == '0);
   assign s_o = result_o[`QCORE_DATA_W-1];

endmodule

// File: verilog/qcore_decode.sv
// Decode stage: field split, condition check, branch decision, hazard interlock, execute register

`include "qcore_macros.svh"

module qcore_decode (
   input  logic                      clk_i,
   input  logic                      rst_ni,
   input  logic                      en_i,
   input  qcore_pkg::instr_t         instr_i,
   input  logic                      valid_i,
   input  logic                      flag_i,     // External condition
   input  logic                      z_i,
   input  logic                      s_i,
   input  qcore_pkg::ctrl_t          x_ctrl_i,   // Instruction now in execute
   input  logic [`QCORE_DATA_W-1:0]  rs0_dt_i,
   input  logic [`QCORE_DATA_W-1:0]  rs1_dt_i,
   output logic [`QCORE_REG_AW-1:0]  rs0_addr_o,
   output logic [`QCORE_REG_AW-1:0]  rs1_addr_o,
   output logic                      stall_o,
   output logic                      branch_taken_o,
   output logic [`QCORE_PMEM_AW-1:0] branch_target_o,
   output qcore_pkg::ctrl_t          ctrl_o,
   output logic [`QCORE_DATA_W-1:0]  op_a_o,
   output logic [`QCORE_DATA_W-1:0]  op_b_o,
   output logic [`QCORE_DATA_W-1:0]  imm_o
);

   logic             is_reg_wr, is_mem_wr, is_br;
   logic             cond_ok, exec_ok;
   logic             use_rs0, use_rs1;
   logic             tests_zs;
   logic             reg_hz, flag_hz, stall;
   qcore_pkg::ctrl_t ctrl_d;

   assign is_reg_wr = valid_i & (instr_i.header == qcore_pkg::REG_WR);
   assign is_mem_wr = valid_i & (instr_i.header == qcore_pkg::MEM_WR);
   assign is_br     = valid_i & (instr_i.header == qcore_pkg::BRANCH);

   ////////////////////////////////////////////////////////////////////
   // Condition
   always_comb begin
      case (instr_i.cond)
         qcore_pkg::ALWAYS: cond_ok = 1'b1;
         qcore_pkg::EQ:     cond_ok = z_i;
         qcore_pkg::LT:     cond_ok = s_i;
         qcore_pkg::NZ:     cond_ok = ~z_i;
         qcore_pkg::NS:     cond_ok = ~s_i;
         qcore_pkg::FLAG:   cond_ok = flag_i;
         qcore_pkg::NFLAG:  cond_ok = ~flag_i;
         default:           cond_ok = 1'b0; // NEVER
      endcase
   end

   ////////////////////////////////////////////////////////////////////
   // Interlock against the instruction in execute
   assign use_rs0  = (is_reg_wr & (instr_i.src != qcore_pkg::IMM)) | is_mem_wr; // Base or A
   assign use_rs1  = (is_reg_wr & (instr_i.src == qcore_pkg::ALU_RR)) | is_mem_wr;
   assign tests_zs = instr_i.cond inside {qcore_pkg::EQ, qcore_pkg::LT,
                                          qcore_pkg::NZ, qcore_pkg::NS};
   assign reg_hz   = x_ctrl_i.reg_we &
                     ((use_rs0 & (x_ctrl_i.rd == instr_i.rs0)) |
                      (use_rs1 & (x_ctrl_i.rd == instr_i.rs1)));
   // Flags settle at the end of execute
   assign flag_hz  = x_ctrl_i.flag_we & tests_zs & (is_reg_wr | is_mem_wr | is_br);
   assign stall    = reg_hz | flag_hz;
   assign exec_ok  = cond_ok & ~stall;

   // Control word, a failed condition or a stall leaves a NOP
   always_comb begin
      ctrl_d         = '0;
      ctrl_d.reg_we  = is_reg_wr & exec_ok;
      ctrl_d.dmem_we = is_mem_wr & exec_ok;
      ctrl_d.dmem_re = ctrl_d.reg_we & (instr_i.src == qcore_pkg::LOAD);
      ctrl_d.flag_we = ctrl_d.reg_we & instr_i.flag_we;
      ctrl_d.alu_op  = instr_i.alu_op;
      ctrl_d.src     = instr_i.src;
      ctrl_d.rd      = instr_i.rd;
   end

   ////////////////////////////////////////////////////////////////////
   // Execute-stage register
   always_ff @(posedge clk_i) begin
      if (!rst_ni)   ctrl_o <= '0;
      else if (en_i) ctrl_o <= ctrl_d;  // Branches go on as NOP
   end

   always_ff @(posedge clk_i) begin
      if (en_i) begin
         op_a_o <= rs0_dt_i;
         op_b_o <= rs1_dt_i;   // Store data for MEM_WR
         imm_o  <= instr_i.imm;
      end
   end

   assign rs0_addr_o      = instr_i.rs0;
   assign rs1_addr_o      = instr_i.rs1;
   assign stall_o         = stall;
   assign branch_taken_o  = is_br & exec_ok;
   assign branch_target_o = instr_i.imm[`QCORE_PMEM_AW-1:0]; // Absolute target

endmodule

// File: verilog/qcore_execute.sv
// Execute stage: ALU operands, data memory access, flag registers, result-stage register

`include "qcore_macros.svh"

module qcore_execute (
   input  logic                      clk_i,
   input  logic                      rst_ni,
   input  logic                      en_i,
   input  qcore_pkg::ctrl_t          ctrl_i,
   input  logic [`QCORE_DATA_W-1:0]  op_a_i,
   input  logic [`QCORE_DATA_W-1:0]  op_b_i,
   input  logic [`QCORE_DATA_W-1:0]  imm_i,
   output logic                      z_o,
   output logic                      s_o,
   output qcore_pkg::ctrl_t          x_ctrl_o,
   output logic                      dmem_we_o,
   output logic [`QCORE_DMEM_AW-1:0] dmem_addr_o,
   output logic [`QCORE_DATA_W-1:0]  dmem_w_dt_o,
   output qcore_pkg::ctrl_t          r_ctrl_o,
   output logic [`QCORE_DATA_W-1:0]  r_alu_o,
   output logic [`QCORE_DATA_W-1:0]  r_imm_o
);

   logic [`QCORE_DATA_W-1:0]  alu_b, alu_res, addr_sum;
   logic                      alu_z, alu_s;
   logic [`QCORE_DMEM_AW-1:0] r_addr_q;  // Address of the instruction in result

   assign alu_b = (ctrl_i.src == qcore_pkg::ALU_RI) ? imm_i : op_b_i;

   qcore_alu alu_i (
      .a_i      (op_a_i),
      .b_i      (alu_b),
      .op_i     (ctrl_i.alu_op),
      .result_o (alu_res),
      .z_o      (alu_z),
      .s_o      (alu_s)
   );

   // Data memory
   assign addr_sum    = op_a_i + imm_i;
   // While halted re-read the result-stage address so a pending load keeps its data
   assign dmem_addr_o = en_i ? addr_sum[`QCORE_DMEM_AW-1:0] : r_addr_q;
   assign dmem_w_dt_o = op_b_i;
   assign dmem_we_o   = en_i & ctrl_i.dmem_we;

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         z_o      <= 1'b0;
         s_o      <= 1'b0;
         r_ctrl_o <= '0;
      end else if (en_i) begin
         if (ctrl_i.flag_we) begin
            z_o <= alu_z;
            s_o <= alu_s;
         end
         r_ctrl_o <= ctrl_i;
      end
   end

   // Result-stage payload
   always_ff @(posedge clk_i) begin
      if (en_i) begin
         r_alu_o  <= alu_res;
         r_imm_o  <= imm_i;
         r_addr_q <= addr_sum[`QCORE_DMEM_AW-1:0];
      end
   end

   assign x_ctrl_o = ctrl_i;  // Seen by the decode interlock

endmodule

// File: verilog/qcore_fetch.sv
// Fetch stage: program counter, program memory request, fetch register and branch flush

`include "qcore_macros.svh"

module qcore_fetch (
   input  logic                      clk_i,
   input  logic                      rst_ni,
   input  logic                      en_i,
   input  logic                      stall_i,         // Decode interlock
   input  logic                      branch_taken_i,
   input  logic [`QCORE_PMEM_AW-1:0] branch_target_i,
   input  logic [`QCORE_INSTR_W-1:0] pmem_dt_i,
   output logic [`QCORE_PMEM_AW-1:0] pmem_addr_o,
   output logic                      pmem_en_o,
   output qcore_pkg::instr_t         instr_o,
   output logic                      valid_o
);

   logic [`QCORE_PMEM_AW-1:0] pc_q;
   logic                      flush_q;  // Word arriving now is wrong path
   logic                      valid_q;
   qcore_pkg::instr_t         instr_q;
   logic                      advance;

   assign advance = en_i & ~stall_i; // Halt and stall both freeze fetch

   // PC and valid tracking
   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         pc_q    <= '0;
         flush_q <= 1'b1;  // First returned word is stale
         valid_q <= 1'b0;
      end else if (advance) begin
         pc_q    <= branch_taken_i ? branch_target_i : pc_q + 1'b1;
         flush_q <= branch_taken_i;  // Kills the word still being read
         valid_q <= ~(branch_taken_i | flush_q);
      end
   end

   // Fetch register
   always_ff @(posedge clk_i) begin
      if (advance) instr_q <= pmem_dt_i;
   end

   assign pmem_addr_o = pc_q;
   assign pmem_en_o   = advance;  // Memory holds its output otherwise
   assign instr_o     = instr_q;
   assign valid_o     = valid_q;

endmodule

// File: verilog/qcore_macros.svh
// Width and depth macros for the sequencer core

`ifndef QCORE_MACROS_SVH
`define QCORE_MACROS_SVH

// Data path
`define QCORE_DATA_W   32   // Register and data word
`define QCORE_REG_AW   4    // 16 registers

// Memory address spaces
`define QCORE_PMEM_AW  8    // Program words
`define QCORE_DMEM_AW  8    // Data words

// Instruction word
`define QCORE_INSTR_W  64
`define QCORE_IMM_W    32   // Immediate field

`endif

// File: verilog/qcore_pkg.sv
// Instruction header, condition, ALU operation, register source and control word types

`include "qcore_macros.svh"

package qcore_pkg;

   // Instruction class, unknown codes act as NOP
   typedef enum logic [2:0] {
      NOP    = 3'd0,
      REG_WR = 3'd1,
      MEM_WR = 3'd2,
      BRANCH = 3'd3
   } header_e;

   // Condition codes on Z, S and the external flag
   typedef enum logic [2:0] {
      ALWAYS = 3'd0,
      EQ     = 3'd1, // Z
      LT     = 3'd2, // S
      NZ     = 3'd3,
      NS     = 3'd4,
      FLAG   = 3'd5, // External flag high
      NFLAG  = 3'd6,
      NEVER  = 3'd7
   } cond_e;

   typedef enum logic [3:0] {
      ADD    = 4'd0,
      SUB    = 4'd1,
      AND    = 4'd2,
      OR     = 4'd3,
      XOR    = 4'd4,
      SHL    = 4'd5,
      SHR    = 4'd6,
      PASS_B = 4'd7
   } alu_op_e;

   // Register write source
   typedef enum logic [1:0] {
      ALU_RR = 2'd0, // rs0 op rs1
      ALU_RI = 2'd1, // rs0 op imm
      IMM    = 2'd2,
      LOAD   = 2'd3  // Data memory at rs0 + imm
   } reg_src_e;

   ////////////////////////////////////////////////////////////////////
   // Instruction word, MSB first
   typedef struct packed {
      logic [6:0]               rsvd;
      header_e                  header;
      cond_e                    cond;
      alu_op_e                  alu_op;
      logic                     flag_we;
      reg_src_e                 src;
      logic [`QCORE_REG_AW-1:0] rd;
      logic [`QCORE_REG_AW-1:0] rs0;
      logic [`QCORE_REG_AW-1:0] rs1;
      logic [`QCORE_IMM_W-1:0]  imm;
   } instr_t;

   // Decoded control, all enables low is a NOP
   typedef struct packed {
      logic                     reg_we;
      logic                     dmem_we;
      logic                     dmem_re;
      logic                     flag_we;
      alu_op_e                  alu_op;
      reg_src_e                 src;
      logic [`QCORE_REG_AW-1:0] rd;
   } ctrl_t;

endpackage

// File: verilog/qcore_reg_bank.sv
// Register bank: sixteen registers, two read ports, one write-through write port

`include "qcore_macros.svh"

module qcore_reg_bank (
   input  logic                     clk_i,
   input  logic                     rst_ni,
   input  logic                     en_i,
   input  logic                     we_i,
   input  logic [`QCORE_REG_AW-1:0] w_addr_i,
   input  logic [`QCORE_DATA_W-1:0] w_dt_i,
   input  logic [`QCORE_REG_AW-1:0] r0_addr_i,
   input  logic [`QCORE_REG_AW-1:0] r1_addr_i,
   output logic [`QCORE_DATA_W-1:0] r0_dt_o,
   output logic [`QCORE_DATA_W-1:0] r1_dt_o
);

   logic [`QCORE_DATA_W-1:0] regs_q [2**`QCORE_REG_AW];
   logic                     wr;

   assign wr = en_i & we_i;  // No writes while halted

   always_ff @(posedge clk_i) begin
      if (!rst_ni)  regs_q <= '{default: '0};
      else if (wr)  regs_q[w_addr_i] <= w_dt_i; // r0 is an ordinary register
   end

   // Same-cycle write is visible to decode
   assign r0_dt_o = (wr && (w_addr_i == r0_addr_i)) ? w_dt_i : regs_q[r0_addr_i];
   assign r1_dt_o = (wr && (w_addr_i == r1_addr_i)) ? w_dt_i : regs_q[r1_addr_i];

endmodule

// File: verilog/qcore_result.sv
// Result stage: register write value select and write port drive

`include "qcore_macros.svh"

module qcore_result (
   input  qcore_pkg::ctrl_t         ctrl_i,
   input  logic [`QCORE_DATA_W-1:0] alu_i,
   input  logic [`QCORE_DATA_W-1:0] imm_i,
   input  logic [`QCORE_DATA_W-1:0] dmem_r_dt_i,  // Returned this cycle
   output logic                     we_o,
   output logic [`QCORE_REG_AW-1:0] addr_o,
   output logic [`QCORE_DATA_W-1:0] dt_o
);

   // Load data lines up with its instruction here
   always_comb begin
      if (ctrl_i.dmem_re)                     dt_o = dmem_r_dt_i;
      else if (ctrl_i.src == qcore_pkg::IMM)  dt_o = imm_i;
      else                                    dt_o = alu_i;  // ALU_RR and ALU_RI
   end

   assign we_o   = ctrl_i.reg_we;  // Already cleared for failed conditions
   assign addr_o = ctrl_i.rd;

endmodule

// File: verilog/qcore_top.sv
// Sequencer core top level: fetch, decode, register bank, execute and result instances

`include "qcore_macros.svh"

module qcore_top (
   input  logic                      clk_i,
   input  logic                      rst_ni,
   input  logic                      en_i,
   input  logic                      flag_i,
   input  logic [`QCORE_INSTR_W-1:0] pmem_dt_i,
   input  logic [`QCORE_DATA_W-1:0]  dmem_r_dt_i,
   output logic [`QCORE_PMEM_AW-1:0] pmem_addr_o,
   output logic                      pmem_en_o,
   output logic                      dmem_we_o,
   output logic [`QCORE_DMEM_AW-1:0] dmem_addr_o,
   output logic [`QCORE_DATA_W-1:0]  dmem_w_dt_o
);

   // Fetch to decode
   qcore_pkg::instr_t         f_instr;
   logic                      f_valid;
   // Decode outputs
   logic                      d_stall, d_branch_taken;
   logic [`QCORE_PMEM_AW-1:0] d_branch_target;
   logic [`QCORE_REG_AW-1:0]  rs0_addr, rs1_addr;
   logic [`QCORE_DATA_W-1:0]  rs0_dt, rs1_dt;
   qcore_pkg::ctrl_t          d_ctrl;
   logic [`QCORE_DATA_W-1:0]  d_op_a, d_op_b, d_imm;
   // Execute outputs
   logic                      x_z, x_s;
   qcore_pkg::ctrl_t          x_ctrl, r_ctrl;
   logic [`QCORE_DATA_W-1:0]  r_alu, r_imm;
   // Write port
   logic                      w_we;
   logic [`QCORE_REG_AW-1:0]  w_addr;
   logic [`QCORE_DATA_W-1:0]  w_dt;

   ////////////////////////////////////////////////////////////////////
   qcore_fetch fetch_i (
      .clk_i(clk_i), .rst_ni(rst_ni), .en_i(en_i),
      .stall_i(d_stall), .branch_taken_i(d_branch_taken),
      .branch_target_i(d_branch_target), .pmem_dt_i(pmem_dt_i),
      .pmem_addr_o(pmem_addr_o), .pmem_en_o(pmem_en_o),
      .instr_o(f_instr), .valid_o(f_valid)
   );

   qcore_decode decode_i (
      .clk_i(clk_i), .rst_ni(rst_ni), .en_i(en_i),
      .instr_i(f_instr), .valid_i(f_valid), .flag_i(flag_i),
      .z_i(x_z), .s_i(x_s), .x_ctrl_i(x_ctrl),
      .rs0_dt_i(rs0_dt), .rs1_dt_i(rs1_dt),
      .rs0_addr_o(rs0_addr), .rs1_addr_o(rs1_addr),
      .stall_o(d_stall), .branch_taken_o(d_branch_taken),
      .branch_target_o(d_branch_target), .ctrl_o(d_ctrl),
      .op_a_o(d_op_a), .op_b_o(d_op_b), .imm_o(d_imm)
   );

   qcore_reg_bank reg_bank_i (
      .clk_i(clk_i), .rst_ni(rst_ni), .en_i(en_i),
      .we_i(w_we), .w_addr_i(w_addr), .w_dt_i(w_dt),
      .r0_addr_i(rs0_addr), .r1_addr_i(rs1_addr),
      .r0_dt_o(rs0_dt), .r1_dt_o(rs1_dt)
   );

   qcore_execute execute_i (
      .clk_i(clk_i), .rst_ni(rst_ni), .en_i(en_i),
      .ctrl_i(d_ctrl), .op_a_i(d_op_a), .op_b_i(d_op_b), .imm_i(d_imm),
      .z_o(x_z), .s_o(x_s), .x_ctrl_o(x_ctrl),
      .dmem_we_o(dmem_we_o), .dmem_addr_o(dmem_addr_o), .dmem_w_dt_o(dmem_w_dt_o),
      .r_ctrl_o(r_ctrl), .r_alu_o(r_alu), .r_imm_o(r_imm)
   );

   qcore_result result_i (
      .ctrl_i(r_ctrl), .alu_i(r_alu), .imm_i(r_imm), .dmem_r_dt_i(dmem_r_dt_i),
      .we_o(w_we), .addr_o(w_addr), .dt_o(w_dt)
   );

endmodule
